// File: src/wdb_macros.svh
`ifndef WDB_MACROS_SVH
`define WDB_MACROS_SVH

// buffer geometry
`define WDB_ENTRY_NUM 8
`define WDB_IDX_W 3 // log2 of entry count
`define WDB_DATA_W 64

// data array and reorder buffer
`define SRAM_ADDR_W 12
`define ROB_IDX_W 5

// cycles from the command strobe
`define ARB_TO_WDB_DELAY 5 // until the buffer read
`define WRITE_DONE_DELAY 20 // until write_done, must exceed read delay + 1

`endif

// File: src/wdb_types_pkg.sv
`include "wdb_macros.svh"

package wdb_types_pkg;

    // index of one write buffer entry
    typedef logic [`WDB_IDX_W-1:0] wdb_idx_t;

    // one write data word, single beat
    typedef logic [`WDB_DATA_W-1:0] wdb_data_t;

    // line address into the data array
    typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

    // reorder buffer slot reported on write_done
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

endpackage

// File: src/wdb_ctrl_pkg.sv
package wdb_ctrl_pkg;

    // pre-allocation slot
    typedef enum logic {
        ALLOC_EMPTY,
        ALLOC_HELD
    } alloc_state_e;

    // owner of the buffer RAM this cycle
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_DRAIN,
        GRANT_FILL
    } wdb_grant_e;

endpackage

// File: src/wdb_ram.sv
`timescale 1ns/1ps
`include "wdb_macros.svh"

module wdb_ram (
    input  logic                     clk,
    input  logic                     ram_en,
    input  logic                     ram_wr_en,
    input  wdb_types_pkg::wdb_idx_t  ram_addr,
    input  wdb_types_pkg::wdb_data_t ram_wr_data,
    output wdb_types_pkg::wdb_data_t ram_rd_data
);

    wdb_types_pkg::wdb_data_t mem [`WDB_ENTRY_NUM];

    // single port, write has no read-through
    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_wr_en) begin
                mem[ram_addr] <= ram_wr_data;
            end else begin
                ram_rd_data <= mem[ram_addr]; // one cycle read latency
            end
        end
    end

endmodule

// File: src/wdb_mem_arbiter.sv
`timescale 1ns/1ps
`include "wdb_macros.svh"

module wdb_mem_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     drain_rd_vld,
    input  wdb_types_pkg::wdb_idx_t  drain_rd_idx,
    input  logic                     write_wdb_vld,
    input  wdb_types_pkg::wdb_idx_t  write_wdb_idx,
    input  wdb_types_pkg::wdb_data_t write_wdb_data,
    output logic                     write_wdb_rdy,
    output logic                     ram_en,
    output logic                     ram_wr_en,
    output wdb_types_pkg::wdb_idx_t  ram_addr,
    output wdb_types_pkg::wdb_data_t ram_wr_data,
    output logic                     free_vld,
    output wdb_types_pkg::wdb_idx_t  free_idx
);

    wdb_ctrl_pkg::wdb_grant_e grant;
    logic [`WDB_ENTRY_NUM-1:0] written; // entry holds unread data

    // drain reads have fixed timing, so they always win
    always_comb begin
        if (drain_rd_vld) begin
            grant = wdb_ctrl_pkg::GRANT_DRAIN;
        end else if (write_wdb_vld) begin
            grant = wdb_ctrl_pkg::GRANT_FILL;
        end else begin
            grant = wdb_ctrl_pkg::GRANT_NONE;
        end
    end

    assign ram_en        = (grant != wdb_ctrl_pkg::GRANT_NONE);
    assign ram_wr_en     = (grant == wdb_ctrl_pkg::GRANT_FILL);
    assign ram_addr      = (grant == wdb_ctrl_pkg::GRANT_DRAIN) ? drain_rd_idx : write_wdb_idx;
    assign ram_wr_data   = write_wdb_data;
    assign write_wdb_rdy = (grant == wdb_ctrl_pkg::GRANT_FILL);

    // a drained entry goes back to the allocator
    assign free_vld = (grant == wdb_ctrl_pkg::GRANT_DRAIN);
    assign free_idx = drain_rd_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            written <= '0;
        end else if (grant == wdb_ctrl_pkg::GRANT_FILL) begin
            written[write_wdb_idx] <= 1'b1;
        end else if (grant == wdb_ctrl_pkg::GRANT_DRAIN) begin
            written[drain_rd_idx] <= 1'b0;
        end
    end

    // command must name an entry that was filled earlier
    a_drain_of_filled: assert property (@(posedge clk) disable iff (!rst_n)
        drain_rd_vld |-> written[drain_rd_idx]);

    // one fill per entry between drains
    a_fill_of_unwritten: assert property (@(posedge clk) disable iff (!rst_n)
        write_wdb_rdy |-> !written[write_wdb_idx]);

endmodule

// File: src/wdb_drain_pipe.sv
`timescale 1ns/1ps
`include "wdb_macros.svh"

module wdb_drain_pipe (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dataram_wr_vld,
    input  wdb_types_pkg::wdb_idx_t    dataram_wr_idx,
    input  wdb_types_pkg::sram_addr_t  dataram_wr_addr,
    input  wdb_types_pkg::rob_idx_t    dataram_wr_rob,
    output logic                       drain_rd_vld,
    output wdb_types_pkg::wdb_idx_t    drain_rd_idx,
    input  wdb_types_pkg::wdb_data_t   ram_rd_data,
    output logic                       write_sram_vld,
    output wdb_types_pkg::sram_addr_t  write_sram_addr,
    output wdb_types_pkg::wdb_data_t   write_sram_data,
    output logic                       write_done,
    output wdb_types_pkg::rob_idx_t    write_done_idx
);

    // stage k holds a command issued k+1 cycles ago
    localparam int RD_TAP   = `ARB_TO_WDB_DELAY - 1;
    localparam int DONE_TAP = `WRITE_DONE_DELAY - 1;

    logic [`WRITE_DONE_DELAY-1:0] vld_sr;
    wdb_types_pkg::wdb_idx_t      idx_sr  [`ARB_TO_WDB_DELAY]; // only needed up to the read
    wdb_types_pkg::sram_addr_t    addr_sr [`ARB_TO_WDB_DELAY];
    wdb_types_pkg::rob_idx_t      rob_sr  [`WRITE_DONE_DELAY];

    logic                      rd_vld_d;  // RAM output valid
    wdb_types_pkg::sram_addr_t rd_addr_d; // address lined up with RAM output

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[`WRITE_DONE_DELAY-2:0], dataram_wr_vld};
        end
    end

    // payload follows the valid bits
    always_ff @(posedge clk) begin
        idx_sr[0]  <= dataram_wr_idx;
        addr_sr[0] <= dataram_wr_addr;
        rob_sr[0]  <= dataram_wr_rob;
        for (int i = 1; i < `ARB_TO_WDB_DELAY; i++) begin
            idx_sr[i]  <= idx_sr[i-1];
            addr_sr[i] <= addr_sr[i-1];
        end
        for (int i = 1; i < `WRITE_DONE_DELAY; i++) begin
            rob_sr[i] <= rob_sr[i-1];
        end
    end

    // read request reaches the buffer after the transport delay
    assign drain_rd_vld = vld_sr[RD_TAP];
    assign drain_rd_idx = idx_sr[RD_TAP];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_d <= 1'b0;
        end else begin
            rd_vld_d <= drain_rd_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (drain_rd_vld) begin
            rd_addr_d <= addr_sr[RD_TAP];
        end
    end

    // data array always ready, beat goes out as soon as data is back
    assign write_sram_vld  = rd_vld_d;
    assign write_sram_addr = rd_addr_d;
    assign write_sram_data = ram_rd_data;

    assign write_done     = vld_sr[DONE_TAP];
    assign write_done_idx = rob_sr[DONE_TAP];

    // done must come after the beat has left
    a_delay_order: assert property (@(posedge clk) disable iff (!rst_n)
        (`WRITE_DONE_DELAY > `ARB_TO_WDB_DELAY + 1));

endmodule

// File: src/wdb_entry_alloc.sv
`timescale 1ns/1ps
`include "wdb_macros.svh"

module wdb_entry_alloc (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    free_vld,
    input  wdb_types_pkg::wdb_idx_t free_idx,
    output logic                    alloc_vld,
    output wdb_types_pkg::wdb_idx_t alloc_idx,
    input  logic                    alloc_rdy
);

    logic [`WDB_ENTRY_NUM-1:0] free_map; // 1 = entry free
    wdb_ctrl_pkg::alloc_state_e state;
    wdb_types_pkg::wdb_idx_t   slot_idx;
    wdb_types_pkg::wdb_idx_t   low_idx;
    logic                      any_free;
    logic                      load;
    logic                      take;

    // lowest free entry, scanned from the top so the last hit wins
    always_comb begin
        low_idx  = '0;
        any_free = 1'b0;
        for (int i = `WDB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                low_idx  = wdb_types_pkg::wdb_idx_t'(i);
                any_free = 1'b1;
            end
        end
    end

    assign load = (state == wdb_ctrl_pkg::ALLOC_EMPTY) && any_free;
    assign take = alloc_vld && alloc_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= wdb_ctrl_pkg::ALLOC_EMPTY;
        end else begin
            case (state)
                wdb_ctrl_pkg::ALLOC_EMPTY: begin
                    if (any_free) begin
                        state <= wdb_ctrl_pkg::ALLOC_HELD;
                    end
                end
                wdb_ctrl_pkg::ALLOC_HELD: begin
                    if (take) begin
                        state <= wdb_ctrl_pkg::ALLOC_EMPTY; // reload next cycle
                    end
                end
                default: state <= wdb_ctrl_pkg::ALLOC_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            slot_idx <= low_idx;
        end
    end

    // held index leaves the map on load, drained ones come back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_map <= '1;
        end else begin
            if (load) begin
                free_map[low_idx] <= 1'b0;
            end
            if (free_vld) begin
                free_map[free_idx] <= 1'b1;
            end
        end
    end

    assign alloc_vld = (state == wdb_ctrl_pkg::ALLOC_HELD);
    assign alloc_idx = slot_idx; // stable while held

    // freeing something free or still on offer means a lost or duplicated entry
    a_no_double_free: assert property (@(posedge clk) disable iff (!rst_n)
        free_vld |-> (!free_map[free_idx] && !(alloc_vld && free_idx == alloc_idx)));

endmodule

// File: src/write_db_agent.sv
`timescale 1ns/1ps

module write_db_agent (
    input  logic                      clk,
    input  logic                      rst_n,

    output logic                      alloc_vld,
    output wdb_types_pkg::wdb_idx_t   alloc_idx,
    input  logic                      alloc_rdy,

    input  logic                      write_wdb_vld,
    input  wdb_types_pkg::wdb_idx_t   write_wdb_idx,
    input  wdb_types_pkg::wdb_data_t  write_wdb_data,
    output logic                      write_wdb_rdy,

    input  logic                      dataram_wr_vld,
    input  wdb_types_pkg::wdb_idx_t   dataram_wr_idx,
    input  wdb_types_pkg::sram_addr_t dataram_wr_addr,
    input  wdb_types_pkg::rob_idx_t   dataram_wr_rob,

    output logic                      write_sram_vld,
    output wdb_types_pkg::sram_addr_t write_sram_addr,
    output wdb_types_pkg::wdb_data_t  write_sram_data,

    output logic                      write_done,
    output wdb_types_pkg::rob_idx_t   write_done_idx
);

    logic                     drain_rd_vld;
    wdb_types_pkg::wdb_idx_t  drain_rd_idx;
    logic                     ram_en;
    logic                     ram_wr_en;
    wdb_types_pkg::wdb_idx_t  ram_addr;
    wdb_types_pkg::wdb_data_t ram_wr_data;
    wdb_types_pkg::wdb_data_t ram_rd_data;
    logic                     free_vld;
    wdb_types_pkg::wdb_idx_t  free_idx;

    wdb_entry_alloc wdb_entry_alloc_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .free_vld  (free_vld),
        .free_idx  (free_idx),
        .alloc_vld (alloc_vld),
        .alloc_idx (alloc_idx),
        .alloc_rdy (alloc_rdy)
    );

    // fill port and drain reads share the RAM
    wdb_mem_arbiter wdb_mem_arbiter_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .drain_rd_vld   (drain_rd_vld),
        .drain_rd_idx   (drain_rd_idx),
        .write_wdb_vld  (write_wdb_vld),
        .write_wdb_idx  (write_wdb_idx),
        .write_wdb_data (write_wdb_data),
        .write_wdb_rdy  (write_wdb_rdy),
        .ram_en         (ram_en),
        .ram_wr_en      (ram_wr_en),
        .ram_addr       (ram_addr),
        .ram_wr_data    (ram_wr_data),
        .free_vld       (free_vld),
        .free_idx       (free_idx)
    );

    wdb_drain_pipe wdb_drain_pipe_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .dataram_wr_vld  (dataram_wr_vld),
        .dataram_wr_idx  (dataram_wr_idx),
        .dataram_wr_addr (dataram_wr_addr),
        .dataram_wr_rob  (dataram_wr_rob),
        .drain_rd_vld    (drain_rd_vld),
        .drain_rd_idx    (drain_rd_idx),
        .ram_rd_data     (ram_rd_data),
        .write_sram_vld  (write_sram_vld),
        .write_sram_addr (write_sram_addr),
        .write_sram_data (write_sram_data),
        .write_done      (write_done),
        .write_done_idx  (write_done_idx)
    );

    wdb_ram wdb_ram_i (
        .clk         (clk),
        .ram_en      (ram_en),
        .ram_wr_en   (ram_wr_en),
        .ram_addr    (ram_addr),
        .ram_wr_data (ram_wr_data),
        .ram_rd_data (ram_rd_data)
    );

endmodule

// File: tb/write_db_agent_tb.sv
`timescale 1ns/1ps
`include "wdb_macros.svh"

module write_db_agent_tb;

    localparam int CLK_PERIOD = 40;
    localparam int N_TESTS    = 5;
    localparam int RAND_OPS   = 200;
    // every random operation counts as one test step
    localparam int WATCHDOG_NS = ((N_TESTS + RAND_OPS) * 40 + 200) * CLK_PERIOD;

    typedef struct {
        int                        beat_cyc;
        int                        done_cyc;
        wdb_types_pkg::wdb_idx_t   idx;
        wdb_types_pkg::sram_addr_t addr;
        wdb_types_pkg::wdb_data_t  data;
        wdb_types_pkg::rob_idx_t   rob;
    } exp_t;

    logic                      clk;
    logic                      rst_n;
    logic                      alloc_vld;
    wdb_types_pkg::wdb_idx_t   alloc_idx;
    logic                      alloc_rdy;
    logic                      write_wdb_vld;
    wdb_types_pkg::wdb_idx_t   write_wdb_idx;
    wdb_types_pkg::wdb_data_t  write_wdb_data;
    logic                      write_wdb_rdy;
    logic                      dataram_wr_vld;
    wdb_types_pkg::wdb_idx_t   dataram_wr_idx;
    wdb_types_pkg::sram_addr_t dataram_wr_addr;
    wdb_types_pkg::rob_idx_t   dataram_wr_rob;
    logic                      write_sram_vld;
    wdb_types_pkg::sram_addr_t write_sram_addr;
    wdb_types_pkg::wdb_data_t  write_sram_data;
    logic                      write_done;
    wdb_types_pkg::rob_idx_t   write_done_idx;

    wdb_types_pkg::wdb_data_t  model_mem [`WDB_ENTRY_NUM]; // buffer contents as filled
    logic [`WDB_ENTRY_NUM-1:0] held = '0; // taken, not yet drained
    exp_t  beat_q[$];
    exp_t  done_q[$];
    int    cyc = 0;
    int    n_checks = 0;
    int    n_errors = 0;
    int    n_passed = 0;
    string cur_test = "reset";

    write_db_agent write_db_agent_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish in time, stuck in %s", cur_test);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("mismatch in %s, %s: expected %0h, actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        n_errors++;
        $display("error in %s: %s", cur_test, msg);
    endtask

    // expected beat and done of a command issued in cycle t0
    function automatic exp_t expect_cmd(input wdb_types_pkg::wdb_idx_t idx,
                                        input wdb_types_pkg::sram_addr_t addr,
                                        input wdb_types_pkg::rob_idx_t rob, input int t0);
        exp_t e;
        e.idx      = idx;
        e.addr     = addr;
        e.rob      = rob;
        e.data     = model_mem[idx];
        e.beat_cyc = t0 + `ARB_TO_WDB_DELAY + 1;
        e.done_cyc = t0 + `WRITE_DONE_DELAY;
        return e;
    endfunction

    // outputs sampled mid-cycle, cyc numbers the cycles
    initial begin
        exp_t e;
        forever begin
            @(negedge clk);
            cyc++;
            if (write_sram_vld) begin
                if (beat_q.size() == 0) begin
                    report_error("SRAM beat with no command pending");
                end else begin
                    e = beat_q.pop_front();
                    check_val("beat cycle", 64'(e.beat_cyc), 64'(cyc));
                    check_val("sram addr", 64'(e.addr), 64'(write_sram_addr));
                    check_val("sram data", e.data, write_sram_data);
                    held[e.idx] = 1'b0; // freed one cycle earlier
                end
            end else if (beat_q.size() > 0 && beat_q[0].beat_cyc <= cyc) begin
                e = beat_q.pop_front();
                held[e.idx] = 1'b0;
                report_error("expected SRAM beat did not arrive");
            end
            if (write_done) begin
                if (done_q.size() == 0) begin
                    report_error("write_done with no command pending");
                end else begin
                    e = done_q.pop_front();
                    check_val("done cycle", 64'(e.done_cyc), 64'(cyc));
                    check_val("done rob", 64'(e.rob), 64'(write_done_idx));
                end
            end else if (done_q.size() > 0 && done_q[0].done_cyc <= cyc) begin
                e = done_q.pop_front();
                report_error("expected write_done did not arrive");
            end
        end
    end

    task automatic take_index(output wdb_types_pkg::wdb_idx_t idx);
        int waited = 0;
        @(posedge clk);
        alloc_rdy <= 1'b1;
        @(negedge clk);
        while (!alloc_vld && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!alloc_vld) begin
            report_error("allocator offered no entry");
        end
        idx = alloc_idx; // taken at the coming edge
        check_val("index offered while held", 64'd0, 64'(held[idx]));
        held[idx] = 1'b1;
        @(posedge clk);
        alloc_rdy <= 1'b0;
    endtask

    task automatic fill_entry(input wdb_types_pkg::wdb_idx_t idx, output int stalls);
        wdb_types_pkg::wdb_data_t data;
        data   = {$urandom, $urandom};
        stalls = 0;
        @(posedge clk);
        write_wdb_vld  <= 1'b1;
        write_wdb_idx  <= idx;
        write_wdb_data <= data;
        @(negedge clk);
        while (!write_wdb_rdy && stalls < 100) begin
            stalls++;
            @(negedge clk);
        end
        if (write_wdb_rdy) begin
            model_mem[idx] = data;
        end else begin
            report_error("fill was never accepted");
        end
        @(posedge clk);
        write_wdb_vld <= 1'b0;
    endtask

    // one command per cycle, back to back
    task automatic issue_cmds(input wdb_types_pkg::wdb_idx_t idxs[$]);
        exp_t e;
        foreach (idxs[i]) begin
            @(posedge clk);
            e = expect_cmd(idxs[i], wdb_types_pkg::sram_addr_t'($urandom),
                           wdb_types_pkg::rob_idx_t'($urandom), cyc + 1);
            dataram_wr_vld  <= 1'b1;
            dataram_wr_idx  <= e.idx;
            dataram_wr_addr <= e.addr;
            dataram_wr_rob  <= e.rob;
            beat_q.push_back(e);
            done_q.push_back(e);
        end
        @(posedge clk);
        dataram_wr_vld <= 1'b0;
    endtask

    task automatic take_fill_issue(input int n);
        wdb_types_pkg::wdb_idx_t q[$];
        wdb_types_pkg::wdb_idx_t idx;
        int stalls;
        repeat (n) begin
            take_index(idx);
            q.push_back(idx);
        end
        foreach (q[i]) fill_entry(q[i], stalls);
        issue_cmds(q);
    endtask

    task automatic end_test(input int errs_before);
        int waited = 0;
        while ((beat_q.size() > 0 || done_q.size() > 0) && waited < 4 * `WRITE_DONE_DELAY) begin
            @(posedge clk);
            waited++;
        end
        if (beat_q.size() > 0 || done_q.size() > 0) begin
            report_error("commands still pending after the drain wait");
        end
        if (n_errors == errs_before) begin
            n_passed++;
            $display("test %s: pass", cur_test);
        end else begin
            $display("test %s: fail, %0d errors", cur_test, n_errors - errs_before);
        end
    endtask

    task automatic test_alloc_after_reset();
        wdb_types_pkg::wdb_idx_t q[$];
        wdb_types_pkg::wdb_idx_t idx;
        int stalls;
        int e0;
        cur_test = "alloc_after_reset";
        e0 = n_errors;
        repeat (`WDB_ENTRY_NUM) begin
            take_index(idx);
            q.push_back(idx);
        end
        check_val("distinct indices", 64'({`WDB_ENTRY_NUM{1'b1}}), 64'(held));
        repeat (4) begin
            @(negedge clk);
            check_val("alloc_vld with all entries held", 64'd0, 64'(alloc_vld));
        end
        foreach (q[i]) fill_entry(q[i], stalls);
        issue_cmds(q); // hands every entry back
        end_test(e0);
    endtask

    task automatic test_spaced_writes();
        int e0;
        cur_test = "spaced_writes";
        e0 = n_errors;
        repeat (4) begin
            take_fill_issue(1);
            repeat (3) @(posedge clk);
        end
        end_test(e0);
    endtask

    task automatic test_fill_during_drain();
        wdb_types_pkg::wdb_idx_t a;
        wdb_types_pkg::wdb_idx_t b;
        wdb_types_pkg::wdb_idx_t q[$];
        int stalls;
        int e0;
        cur_test = "fill_during_drain";
        e0 = n_errors;
        take_index(a);
        take_index(b);
        fill_entry(a, stalls);
        q.push_back(a);
        issue_cmds(q); // returns at the edge after the command cycle
        repeat (`ARB_TO_WDB_DELAY - 2) @(posedge clk);
        fill_entry(b, stalls); // valid from the drain-read cycle on
        check_val("fill stall cycles", 64'd1, 64'(stalls));
        q.delete();
        q.push_back(b);
        issue_cmds(q);
        end_test(e0);
    endtask

    task automatic test_back_to_back();
        int e0;
        cur_test = "back_to_back";
        e0 = n_errors;
        take_fill_issue(5);
        end_test(e0);
    endtask

    task automatic test_random_ops();
        wdb_types_pkg::wdb_idx_t taken[$];
        wdb_types_pkg::wdb_idx_t filled[$];
        wdb_types_pkg::wdb_idx_t burst[$];
        wdb_types_pkg::wdb_idx_t idx;
        int op;
        int n;
        int stalls;
        int e0;
        cur_test = "random_ops";
        e0 = n_errors;
        for (int k = 0; k < RAND_OPS; k++) begin
            op = $urandom_range(0, 2);
            if (op == 0 && taken.size() + filled.size() < `WDB_ENTRY_NUM) begin
                take_index(idx);
                taken.push_back(idx);
            end else if (op == 1 && taken.size() > 0) begin
                idx = taken.pop_front();
                fill_entry(idx, stalls);
                filled.push_back(idx);
            end else if (filled.size() > 0) begin
                n = $urandom_range(1, 3);
                burst.delete();
                while (n > 0 && filled.size() > 0) begin
                    burst.push_back(filled.pop_front());
                    n--;
                end
                issue_cmds(burst);
            end else begin
                @(posedge clk); // idle step
            end
        end
        while (taken.size() > 0) begin
            idx = taken.pop_front();
            fill_entry(idx, stalls);
            filled.push_back(idx);
        end
        issue_cmds(filled);
        end_test(e0);
    endtask

    initial begin
        rst_n           = 1'b0;
        alloc_rdy       = 1'b0;
        write_wdb_vld   = 1'b0;
        write_wdb_idx   = '0;
        write_wdb_data  = '0;
        dataram_wr_vld  = 1'b0;
        dataram_wr_idx  = '0;
        dataram_wr_addr = '0;
        dataram_wr_rob  = '0;
        void'($urandom(32'h3669_6e15));
        repeat (2) @(posedge clk);
        @(negedge clk); // outputs while reset is still low
        check_val("alloc_vld in reset", 64'd0, 64'(alloc_vld));
        check_val("write_wdb_rdy in reset", 64'd0, 64'(write_wdb_rdy));
        check_val("write_sram_vld in reset", 64'd0, 64'(write_sram_vld));
        check_val("write_done in reset", 64'd0, 64'(write_done));
        @(posedge clk);
        rst_n <= 1'b1;
        test_alloc_after_reset();
        test_spaced_writes();
        test_fill_during_drain();
        test_back_to_back();
        test_random_ops();
        $display("tests passed %0d of %0d, checks %0d, errors %0d",
                 n_passed, N_TESTS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
src/wdb_types_pkg.sv
src/wdb_ctrl_pkg.sv
src/wdb_ram.sv
src/wdb_mem_arbiter.sv
src/wdb_drain_pipe.sv
src/wdb_entry_alloc.sv
src/write_db_agent.sv
tb/write_db_agent_tb.sv

// File: Makefile
TOP := write_db_agent_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): verilog.f $(wildcard src/*.sv src/*.svh tb/*.sv)
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "ALL CHECKS PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log
